// File: hdl/lpf_pkg.sv
// Shared types and width constants for the MIDI low-pass filter, used by scoped name
package lpf_pkg;

    // ----------------------------------------------------------------------
    // Arithmetic widths
    // ----------------------------------------------------------------------
    localparam int SAMPLE_W    = 18;
    // One MIDI data byte
    localparam int COEF_W      = 7;
    // Gain of 16 is unity
    localparam int GAIN_FRAC   = 4;
    // Alpha is a fraction of 128
    localparam int CUTOFF_FRAC = 7;

    // Audio sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // MIDI status nibbles
    typedef enum logic [3:0] {
        MIDI_NOTE_OFF   = 4'h8,
        MIDI_NOTE_ON    = 4'h9,
        MIDI_POLY_PRESS = 4'hA,
        MIDI_CC         = 4'hB,
        MIDI_PROGRAM    = 4'hC,
        MIDI_CHAN_PRESS = 4'hD,
        MIDI_PITCH_BEND = 4'hE,
        MIDI_SYSTEM     = 4'hF
    } midi_cmd_e;

    // One MIDI event as delivered with midi_rdy
    typedef struct packed {
        midi_cmd_e  cmd;
        logic [3:0] chan;
        // Controller number for CC
        logic [6:0] data0;
        // Controller value for CC
        logic [6:0] data1;
    } midi_msg_t;

    // Filter parameter set
    typedef struct packed {
        logic [COEF_W-1:0] alpha;
        logic [COEF_W-1:0] gain;
    } lpf_params_t;

    // Execute sequencer states
    typedef enum logic [1:0] {
        EX_IDLE,
        EX_STAGE1,
        EX_STAGE2,
        EX_DONE
    } exec_state_e;

    // Power-up parameter values, half cutoff and unity gain
    localparam logic [COEF_W-1:0] ALPHA_RESET = 7'd64;
    localparam logic [COEF_W-1:0] GAIN_RESET  = 7'd16;

endpackage

// File: hdl/midi_cc_decode.sv
// MIDI control-change decoder; holds the cutoff and gain parameters for the filter
module midi_cc_decode #(
    parameter logic [3:0] MIDI_CHANNEL = 4'd0,
    parameter logic [6:0] CUTOFF_CC    = 7'd74,
    parameter logic [6:0] GAIN_CC      = 7'd7
) (
    input  logic                clk,
    input  logic                reset,

    // MIDI event strobe, message valid while high
    input  logic                midi_rdy,
    input  lpf_pkg::midi_msg_t  midi_msg,

    // Current parameter set
    output lpf_pkg::lpf_params_t params
);

    // ----------------------------------------------------------------------
    // Event qualification
    // ----------------------------------------------------------------------
    logic cc_event;
    logic cutoff_hit;
    logic gain_hit;

    // Only CC on our channel counts
    assign cc_event = midi_rdy &&
                      (midi_msg.cmd == lpf_pkg::MIDI_CC) &&
                      (midi_msg.chan == MIDI_CHANNEL);

    // Controller select
    assign cutoff_hit = cc_event && (midi_msg.data0 == CUTOFF_CC);
    assign gain_hit   = cc_event && (midi_msg.data0 == GAIN_CC);

    // ----------------------------------------------------------------------
    // Parameter registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            params.alpha <= lpf_pkg::ALPHA_RESET;
            params.gain  <= lpf_pkg::GAIN_RESET;
        end
        else begin
            // Value comes from the second data byte
            if (cutoff_hit) begin
                params.alpha <= midi_msg.data1;
            end
            if (gain_hit) begin
                params.gain <= midi_msg.data1;
            end
        end
    end

endmodule

// File: hdl/lpf_execute.sv
// Two-stage one-pole IIR low-pass sequencer sharing a single multiplier across stages
module lpf_execute (
    input  logic                          clk,
    input  logic                          reset,

    // Sample input, strobe only honored when idle
    input  logic                          sample_in_rdy,
    input  lpf_pkg::sample_t              sample_in,

    // Live parameters from the decoder
    input  lpf_pkg::lpf_params_t          params,

    // Second-stage output and the gain captured with it
    output logic                          stage_rdy,
    output lpf_pkg::sample_t              stage_out,
    output logic [lpf_pkg::COEF_W-1:0]    gain
);

    // Difference needs one extra bit
    localparam int DIFF_W = lpf_pkg::SAMPLE_W + 1;
    // Difference times alpha with a zero sign bit
    localparam int PROD_W = DIFF_W + lpf_pkg::COEF_W + 1;

    // ----------------------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------------------
    lpf_pkg::exec_state_e state;
    lpf_pkg::exec_state_e next_state;

    logic accept;

    assign accept = (state == lpf_pkg::EX_IDLE) && sample_in_rdy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= lpf_pkg::EX_IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lpf_pkg::EX_IDLE:   if (sample_in_rdy) next_state = lpf_pkg::EX_STAGE1;
            lpf_pkg::EX_STAGE1: next_state = lpf_pkg::EX_STAGE2;
            lpf_pkg::EX_STAGE2: next_state = lpf_pkg::EX_DONE;
            lpf_pkg::EX_DONE:   next_state = lpf_pkg::EX_IDLE;
            default:            next_state = lpf_pkg::EX_IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // Per-sample capture
    // ----------------------------------------------------------------------
    lpf_pkg::sample_t           x_q;
    logic [lpf_pkg::COEF_W-1:0] alpha_q;
    logic [lpf_pkg::COEF_W-1:0] gain_q;

    // Parameters frozen for the whole sample
    always_ff @(posedge clk) begin
        if (accept) begin
            x_q     <= sample_in;
            alpha_q <= params.alpha;
            gain_q  <= params.gain;
        end
    end

    // ----------------------------------------------------------------------
    // Shared multiplier datapath
    // ----------------------------------------------------------------------
    lpf_pkg::sample_t          y1;
    lpf_pkg::sample_t          y2;
    lpf_pkg::sample_t          in_sel;
    lpf_pkg::sample_t          y_sel;
    logic signed [DIFF_W-1:0]  diff;
    logic signed [lpf_pkg::COEF_W:0] alpha_s;
    logic signed [PROD_W-1:0]  product;
    logic signed [PROD_W-1:0]  step;
    logic signed [DIFF_W-1:0]  y_next;

    // Stage 1 filters x into y1, stage 2 filters y1 into y2
    always_comb begin
        if (state == lpf_pkg::EX_STAGE2) begin
            in_sel = y1;
            y_sel  = y2;
        end
        else begin
            in_sel = x_q;
            y_sel  = y1;
        end
    end

    assign diff    = DIFF_W'(in_sel) - DIFF_W'(y_sel);
    assign alpha_s = $signed({1'b0, alpha_q});
    assign product = diff * alpha_s;
    // Floor division by 128
    assign step    = product >>> lpf_pkg::CUTOFF_FRAC;
    // Fits in 18 bits since alpha stays below one
    assign y_next  = DIFF_W'(y_sel) + step[DIFF_W-1:0];

    // Filter state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y1 <= '0;
            y2 <= '0;
        end
        else if (state == lpf_pkg::EX_STAGE1) begin
            y1 <= y_next[lpf_pkg::SAMPLE_W-1:0];
        end
        else if (state == lpf_pkg::EX_STAGE2) begin
            y2 <= y_next[lpf_pkg::SAMPLE_W-1:0];
        end
    end

    // Result handoff, valid in EX_DONE only
    assign stage_rdy = (state == lpf_pkg::EX_DONE);
    assign stage_out = y2;
    assign gain      = gain_q;

endmodule

// File: hdl/lpf_result.sv
// Output stage applying gain with 18-bit saturation and an overflow flag
module lpf_result (
    input  logic                       clk,
    input  logic                       reset,

    // Filtered sample from execute
    input  logic                       stage_rdy,
    input  lpf_pkg::sample_t           stage_out,
    input  logic [lpf_pkg::COEF_W-1:0] gain,

    // Registered output
    output logic                       sample_out_rdy,
    output lpf_pkg::sample_t           sample_out,
    output logic                       err_overflow
);

    localparam int PROD_W = lpf_pkg::SAMPLE_W + lpf_pkg::COEF_W + 1;

    // ----------------------------------------------------------------------
    // Gain and saturation
    // ----------------------------------------------------------------------
    logic signed [PROD_W-1:0]   product;
    logic signed [PROD_W-1:0]   scaled;
    logic [PROD_W-lpf_pkg::SAMPLE_W:0] upper;
    logic                       ovf;
    lpf_pkg::sample_t           sat;

    assign product = stage_out * $signed({1'b0, gain});
    // Drop the gain fraction, floor
    assign scaled  = product >>> lpf_pkg::GAIN_FRAC;

    // Upper bits must all match the sign, else out of range
    assign upper = scaled[PROD_W-1:lpf_pkg::SAMPLE_W-1];
    assign ovf   = (&upper) ^ (|upper);

    // Clamp toward the sign of the product
    assign sat = !ovf                ? scaled[lpf_pkg::SAMPLE_W-1:0] :
                 scaled[PROD_W-1]    ? {1'b1, {(lpf_pkg::SAMPLE_W-1){1'b0}}} :
                                       {1'b0, {(lpf_pkg::SAMPLE_W-1){1'b1}}};

    // Output register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_out_rdy <= 1'b0;
            err_overflow   <= 1'b0;
            sample_out     <= '0;
        end
        else begin
            sample_out_rdy <= stage_rdy;
            err_overflow   <= stage_rdy && ovf;
            if (stage_rdy) begin
                sample_out <= sat;
            end
        end
    end

endmodule

// File: hdl/midi_lpf_top.sv
// Top level of the MIDI-controlled low-pass filter; connects decode, execute and result
module midi_lpf_top #(
    parameter logic [3:0] MIDI_CHANNEL = 4'd0,
    parameter logic [6:0] CUTOFF_CC    = 7'd74,
    parameter logic [6:0] GAIN_CC      = 7'd7
) (
    input  logic               clk,
    input  logic               reset,

    // MIDI event input
    input  logic               midi_rdy,
    input  lpf_pkg::midi_msg_t midi_msg,

    // Sample stream
    input  logic               sample_in_rdy,
    input  lpf_pkg::sample_t   sample_in,
    output logic               sample_out_rdy,
    output lpf_pkg::sample_t   sample_out,
    output logic               err_overflow
);

    // ----------------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------------
    lpf_pkg::lpf_params_t       params;
    logic                       stage_rdy;
    lpf_pkg::sample_t           stage_out;
    logic [lpf_pkg::COEF_W-1:0] gain;

    // CC decode, one cycle latency
    midi_cc_decode #(
        .MIDI_CHANNEL (MIDI_CHANNEL),
        .CUTOFF_CC    (CUTOFF_CC),
        .GAIN_CC      (GAIN_CC)
    ) decode0 (
        .clk      (clk),
        .reset    (reset),
        .midi_rdy (midi_rdy),
        .midi_msg (midi_msg),
        .params   (params)
    );

    // Two IIR stages, three cycles per sample
    lpf_execute execute0 (
        .clk           (clk),
        .reset         (reset),
        .sample_in_rdy (sample_in_rdy),
        .sample_in     (sample_in),
        .params        (params),
        .stage_rdy     (stage_rdy),
        .stage_out     (stage_out),
        .gain          (gain)
    );

    // Gain, clamp and output register
    lpf_result result0 (
        .clk            (clk),
        .reset          (reset),
        .stage_rdy      (stage_rdy),
        .stage_out      (stage_out),
        .gain           (gain),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out),
        .err_overflow   (err_overflow)
    );

endmodule

// File: test/tb_midi_lpf.sv
// Self-checking testbench for midi_lpf_top; replays the stimulus records of test/lpf_input.txt
module tb_midi_lpf;
    timeunit 1ns;
    timeprecision 1ps;

    // Output strobe wait limit and expected latency in cycles
    localparam int OUT_TIMEOUT = 20;
    localparam int LATENCY     = 4;

    logic               clk;
    logic               reset;
    logic               midi_rdy;
    lpf_pkg::midi_msg_t midi_msg;
    logic               sample_in_rdy;
    lpf_pkg::sample_t   sample_in;
    logic               sample_out_rdy;
    lpf_pkg::sample_t   sample_out;
    logic               err_overflow;

    // Bookkeeping
    integer seed;
    int     pass_count;
    int     fail_count;
    int     group_errors;
    bit     aborted;
    string  group_name;

    midi_lpf_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .midi_rdy       (midi_rdy),
        .midi_msg       (midi_msg),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out),
        .err_overflow   (err_overflow)
    );

    // 100 ns clock
    always begin
        #50 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Stimulus tasks
    // ----------------------------------------------------------------------
    // Drive point 5 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // Quiet cycles with no output strobe allowed
    task automatic idle_cycles(input int n);
        repeat (n) begin
            next_cycle();
            assert (!sample_out_rdy) else begin
                $display("Unexpected sample_out_rdy pulse with no sample pending");
                group_errors++;
            end
        end
    endtask

    // One-cycle MIDI event
    task automatic send_midi(input int cmd, input int chan, input int d0, input int d1);
        midi_msg.cmd   = lpf_pkg::midi_cmd_e'(4'(cmd));
        midi_msg.chan  = 4'(chan);
        midi_msg.data0 = 7'(d0);
        midi_msg.data1 = 7'(d1);
        midi_rdy       = 1'b1;
        next_cycle();
        midi_rdy       = 1'b0;
    endtask

    // Sample strobe and optional busy strobe followed by the result wait
    task automatic run_sample(input int x, input bit busy, input int busy_x,
                              input int exp, input int exp_ovf);
        lpf_pkg::sample_t exp_s;
        int               cycles;
        int               gap;
        exp_s         = lpf_pkg::sample_t'(exp);
        sample_in     = lpf_pkg::sample_t'(x);
        sample_in_rdy = 1'b1;
        next_cycle();
        cycles = 1;
        // Extra strobe lands in EX_STAGE1
        if (busy) begin
            sample_in = lpf_pkg::sample_t'(busy_x);
        end
        else begin
            sample_in_rdy = 1'b0;
        end
        while (!sample_out_rdy && cycles < OUT_TIMEOUT) begin
            next_cycle();
            sample_in_rdy = 1'b0;
            cycles++;
        end
        assert (sample_out_rdy) else begin
            $display("No sample_out_rdy within %0d cycles of a sample strobe", OUT_TIMEOUT);
            group_errors++;
            aborted = 1'b1;
        end
        if (!aborted) begin
            assert (cycles == LATENCY) else begin
                $display("[FAIL] sample_out_rdy latency expected %0h got %0h", LATENCY, cycles);
                group_errors++;
            end
            assert (sample_out == exp_s) else begin
                $display("[FAIL] sample_out expected %05h got %05h", exp_s, sample_out);
                group_errors++;
            end
            assert (err_overflow == 1'(exp_ovf)) else begin
                $display("[FAIL] err_overflow expected %0h got %0h", exp_ovf, err_overflow);
                group_errors++;
            end
            // Random spacing of 8 to 15 cycles
            gap = 8 + int'({$random(seed)} % 32'd8);
            idle_cycles(gap);
        end
    endtask

    // Record whose fields did not parse
    task automatic reject_record(input string text);
        $display("Malformed record in the stimulus file: %s", text);
        group_errors++;
    endtask

    // Result line for the group just finished
    task automatic close_group();
        if (group_errors == 0) begin
            pass_count++;
            $display("test %-16s ok", group_name);
        end
        else begin
            fail_count++;
            $display("test %-16s FAIL (%0d errors)", group_name, group_errors);
        end
        group_errors = 0;
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int    fd;
        int    n;
        int    a;
        int    b;
        int    c;
        int    d;
        string line;
        string name;
        clk           = 1'b0;
        reset         = 1'b1;
        midi_rdy      = 1'b0;
        midi_msg      = '0;
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        seed          = 32'hd0438e8e;
        pass_count    = 0;
        fail_count    = 0;
        group_errors  = 0;
        aborted       = 1'b0;
        group_name    = "reset_state";

        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;
        next_cycle();
        // Outputs cleared by reset
        assert (!sample_out_rdy && !err_overflow) else begin
            $display("Output strobes not low after reset");
            group_errors++;
        end
        assert (sample_out == '0) else begin
            $display("[FAIL] sample_out expected %05h got %05h", 18'h0, sample_out);
            group_errors++;
        end

        fd = $fopen("test/lpf_input.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the stimulus file test/lpf_input.txt");
            group_errors++;
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip blanks and comments
            if (n == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            case (line[0])
                "T": begin
                    close_group();
                    n = $sscanf(line, "T %s", name);
                    group_name = name;
                    if (n != 1) begin
                        reject_record(line);
                    end
                end
                "M": begin
                    n = $sscanf(line, "M %h %d %d %d", a, b, c, d);
                    if (n == 4) begin
                        send_midi(a, b, c, d);
                    end
                    else begin
                        reject_record(line);
                    end
                end
                "S": begin
                    n = $sscanf(line, "S %d %d %d", a, c, d);
                    if (n == 3) begin
                        run_sample(a, 1'b0, 0, c, d);
                    end
                    else begin
                        reject_record(line);
                    end
                end
                "B": begin
                    n = $sscanf(line, "B %d %d %d %d", a, b, c, d);
                    if (n == 4) begin
                        run_sample(a, 1'b1, b, c, d);
                    end
                    else begin
                        reject_record(line);
                    end
                end
                "I": begin
                    n = $sscanf(line, "I %d", a);
                    if (n == 1) begin
                        idle_cycles(a);
                    end
                    else begin
                        reject_record(line);
                    end
                end
                default: begin
                    $display("Unknown record in the stimulus file: %s", line);
                    group_errors++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        close_group();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !aborted) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: test/lpf_input.txt
# T name | M cmd(hex) chan data0 data1 | S sample expected_out expected_ovf | I cycles
# B sample busy_sample expected_out expected_ovf; all values decimal except cmd
T reset_step
S 65536 16384 0
S 65536 32768 0
S 65536 45056 0
S 65536 53248 0
S 65536 58368 0
S 65536 61440 0
T cutoff_cc
M b 0 74 16
I 2
S 0 60816 0
S 0 59388 0
S 0 57366 0
S 0 54922 0
T cmd_chan_filter
M b 3 74 100
M 9 0 7 127
M b 0 20 100
S 0 52192 0
S 0 49287 0
T gain_overflow
M b 0 7 127
S 0 131071 1
M b 0 74 127
S -131072 -131072 1
M b 0 7 16
S -131072 -131043 0
T busy_strobe
B 0 131071 -2040 0
S 0 -24 0

// File: sim.f
hdl/lpf_pkg.sv
hdl/midi_cc_decode.sv
hdl/lpf_execute.sv
hdl/lpf_result.sv
hdl/midi_lpf_top.sv
test/tb_midi_lpf.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/tb_midi_lpf: sim.f $(wildcard hdl/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_midi_lpf -o tb_midi_lpf

run: obj_dir/tb_midi_lpf
	obj_dir/tb_midi_lpf | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module tb_midi_lpf

clean:
	rm -rf obj_dir sim.log
